// File: build.sh
#!/bin/sh
# compile the vic_sim testbench with verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module vic_tb -Mdir obj_dir -o vic_tb_sim \
   -f vic_sim.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/vic_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

exit 0

// File: src/cpu_bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_regs (
   input  wire                clk_dot4x,
   input  wire                rst_n,
   input  wire                ce,          // chip enable, low active
   input  wire                rw,          // high = read
   input  wire vic_pkg::reg_addr_t adi,
   input  wire  [7:0]         dbi,
   input  wire  [7:0]         raster_y,    // current line from timing
   input  wire                raster_hit,  // one cycle compare event
   output logic [7:0]         dbo,
   output logic               db_oe,
   output logic               irq,         // low active
   output logic               den,
   output logic [7:0]         raster_cmp,
   output vic_pkg::color_t    border,
   output vic_pkg::color_t    bg0,
   output vic_pkg::color_t    bg1
);

   import vic_pkg::*;

   logic       wr_acc;     // cpu write this cycle
   logic       rd_acc;     // cpu read this cycle
   logic       irq_en;     // raster irq enable
   logic       irq_stat;   // raster event latched
   logic [7:0] rd_data;    // read mux result

   assign wr_acc = !ce && !rw;
   assign rd_acc = !ce && rw;

   // register writes
   always_ff @(posedge clk_dot4x) begin
      if (!rst_n) begin
         den        <= 1'b0;
         raster_cmp <= 8'd0;
         irq_en     <= 1'b0;
         border     <= '0;
         bg0        <= '0;
         bg1        <= '0;
      end else if (wr_acc) begin
         case (adi)
            reg_ctrl:   den        <= dbi[4];     // only den is kept
            reg_raster: raster_cmp <= dbi;
            reg_irq_en: irq_en     <= dbi[0];
            reg_border: border     <= dbi[3:0];
            reg_bg0:    bg0        <= dbi[3:0];
            reg_bg1:    bg1        <= dbi[3:0];
            default: ;                            // unmapped, ignore
         endcase
      end
   end

   // interrupt status, write 1 to clear
   always_ff @(posedge clk_dot4x) begin
      if (!rst_n)
         irq_stat <= 1'b0;
      else if (raster_hit)
         irq_stat <= 1'b1;   // a hit wins over a clear on the same edge
      else if (wr_acc && (adi == reg_irq_stat) && dbi[0])
         irq_stat <= 1'b0;
   end

   assign irq = !(irq_stat && irq_en);   // open-drain style, low when pending

   // read-back, unused bits as 1
   always_comb begin
      case (adi)
         reg_ctrl:     rd_data = {3'b111, den, 4'b1111};
         reg_raster:   rd_data = raster_y;
         reg_irq_stat: rd_data = {irq_stat && irq_en, 6'b111111, irq_stat};
         reg_irq_en:   rd_data = {7'b1111111, irq_en};
         reg_border:   rd_data = {4'hf, border};
         reg_bg0:      rd_data = {4'hf, bg0};
         reg_bg1:      rd_data = {4'hf, bg1};
         default:      rd_data = 8'hff;               // open bus
      endcase
   end

   // dbo holds the last read value
   always_ff @(posedge clk_dot4x) begin
      if (rd_acc)
         dbo <= rd_data;
   end

   always_ff @(posedge clk_dot4x) begin
      if (!rst_n)
         db_oe <= 1'b0;
      else
         db_oe <= rd_acc;    // one cycle drive window per access
   end

   // a bus access is a single ce-low cycle, so the data driver never stays on
   assert property (@(posedge clk_dot4x) disable iff (!rst_n) db_oe |=> !db_oe)
      else $error("db_oe high on two consecutive cycles");

endmodule

`default_nettype wire

// File: src/palette_rgb.sv
`timescale 1ns/1ps
`default_nettype none

module palette_rgb (
   input  wire             clk_dot4x,
   input  wire             rst_n,
   input  wire             pix_en,
   input  wire vic_pkg::color_t color_idx,
   input  wire             hs_q,
   input  wire             vs_q,
   input  wire             vis_q,
   output vic_pkg::rgb6_t  red,
   output vic_pkg::rgb6_t  green,
   output vic_pkg::rgb6_t  blue,
   output logic            hsync,
   output logic            vsync,
   output logic            active,
   output logic            pix_valid   // new pixel on the outputs
);

   import vic_pkg::*;

   always_ff @(posedge clk_dot4x) begin
      if (!rst_n) begin
         red    <= '0;
         green  <= '0;
         blue   <= '0;
         hsync  <= 1'b0;
         vsync  <= 1'b0;
         active <= 1'b0;
      end else if (pix_en) begin
         red    <= palette_r[color_idx];   // index 0 in blanking is black
         green  <= palette_g[color_idx];
         blue   <= palette_b[color_idx];
         hsync  <= hs_q;
         vsync  <= vs_q;
         active <= vis_q;
      end
   end

   // the outputs above change on the same edge
   always_ff @(posedge clk_dot4x) begin
      if (!rst_n)
         pix_valid <= 1'b0;
      else
         pix_valid <= pix_en;
   end

   // blanking from the timing stage must reach the rgb lines as black
   assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                    !active |-> (red == '0) && (green == '0) && (blue == '0))
      else $error("rgb not black outside the visible area");

endmodule

`default_nettype wire

// File: src/pixel_color.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_color (
   input  wire             clk_dot4x,
   input  wire             rst_n,
   input  wire             pix_en,
   input  wire  [7:0]      x,
   input  wire  [7:0]      y,
   input  wire             hs,
   input  wire             vs,
   input  wire             vis,
   input  wire             in_win,
   input  wire             den,       // display enable
   input  wire vic_pkg::color_t border,
   input  wire vic_pkg::color_t bg0,
   input  wire vic_pkg::color_t bg1,
   output vic_pkg::color_t color_idx,
   output logic            hs_q,
   output logic            vs_q,
   output logic            vis_q
);

   import vic_pkg::*;

   color_t color_next;   // colour of the pixel at x,y

   always_comb begin
      if (!vis)
         color_next = '0;                          // blanked
      else if (in_win && den)
         color_next = (x[2] ^ y[2]) ? bg1 : bg0;   // 4x4 checker
      else
         color_next = border;
   end

   // colour of the pixel latched on the strobe
   always_ff @(posedge clk_dot4x) begin
      if (!rst_n)
         color_idx <= '0;
      else if (pix_en)
         color_idx <= color_next;
   end

   always_ff @(posedge clk_dot4x) begin
      if (!rst_n) begin
         hs_q  <= 1'b0;
         vs_q  <= 1'b0;
         vis_q <= 1'b0;
      end else if (pix_en) begin
         hs_q  <= hs;    // keep syncs in step with the colour
         vs_q  <= vs;
         vis_q <= vis;
      end
   end

endmodule

`default_nettype wire

// File: src/raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

module raster_timing #(
   parameter int h_total  = 48,   // pixels per line
   parameter int v_total  = 20,   // lines per frame
   parameter int win_x0   = 8,    // display window, half open ranges
   parameter int win_x1   = 32,
   parameter int win_y0   = 4,
   parameter int win_y1   = 12,
   parameter int h_vis    = 40,   // visible width
   parameter int v_vis    = 16,   // visible height
   parameter int hs_start = 42,
   parameter int hs_len   = 4,
   parameter int vs_start = 17,
   parameter int vs_len   = 2
) (
   input  wire        clk_dot4x,
   input  wire        rst_n,
   input  wire  [7:0] raster_cmp,   // compare line from register bank
   output logic       pix_en,       // one pulse every 4 clocks
   output logic [7:0] x,
   output logic [7:0] y,
   output logic       hs,
   output logic       vs,
   output logic       vis,
   output logic       in_win,
   output logic       raster_hit
);

   logic [1:0] div;   // dot4x to pixel divider

   always_ff @(posedge clk_dot4x) begin
      if (!rst_n)
         div <= 2'd0;
      else
         div <= div + 2'd1;
   end

   assign pix_en = (div == 2'd3);

   // raster counters, x fastest
   always_ff @(posedge clk_dot4x) begin
      if (!rst_n) begin
         x <= 8'd0;
         y <= 8'd0;
      end else if (pix_en) begin
         if (x == 8'(h_total - 1)) begin
            x <= 8'd0;                                    // end of line
            y <= (y == 8'(v_total - 1)) ? 8'd0 : y + 8'd1; // wrap at frame end
         end else begin
            x <= x + 8'd1;
         end
      end
   end

   // sync decode
   assign hs = (x >= 8'(hs_start)) && (x < 8'(hs_start + hs_len));
   assign vs = (y >= 8'(vs_start)) && (y < 8'(vs_start + vs_len));

   assign vis    = (x < 8'(h_vis)) && (y < 8'(v_vis));   // blanking elsewhere
   assign in_win = (x >= 8'(win_x0)) && (x < 8'(win_x1)) &&
                   (y >= 8'(win_y0)) && (y < 8'(win_y1));

   // fires once per frame at the start of the compare line
   assign raster_hit = pix_en && (x == 8'd0) && (y == raster_cmp);

   // counters never leave the raster, whatever the parameter set
   assert property (@(posedge clk_dot4x) disable iff (!rst_n)
                    (x < 8'(h_total)) && (y < 8'(v_total)))
      else $error("raster position out of range x=%0d y=%0d", x, y);

endmodule

`default_nettype wire

// File: src/vic_pkg.sv
`default_nettype none

package vic_pkg;

   typedef logic [3:0] color_t;      // palette index, the chip colour number
   typedef logic [5:0] rgb6_t;       // one analog rgb channel
   typedef logic [5:0] reg_addr_t;   // register address on adi

   // register map
   localparam reg_addr_t reg_ctrl     = 6'h11;  // bit 4 = den
   localparam reg_addr_t reg_raster   = 6'h12;  // wr: compare line, rd: current line
   localparam reg_addr_t reg_irq_stat = 6'h19;  // bit 0 raster, bit 7 any pending
   localparam reg_addr_t reg_irq_en   = 6'h1a;  // bit 0 raster enable
   localparam reg_addr_t reg_border   = 6'h20;
   localparam reg_addr_t reg_bg0      = 6'h21;
   localparam reg_addr_t reg_bg1      = 6'h22;

   // 16 colour palette, 6 bits per channel
   // order: black white red cyan purple green blue yellow
   //        orange brown lt-red dk-grey grey lt-green lt-blue lt-grey
   localparam rgb6_t palette_r [0:15] = '{
      6'd0,  6'd63, 6'd43, 6'd24, 6'd44, 6'd18, 6'd13, 6'd57,
      6'd45, 6'd26, 6'd58, 6'd19, 6'd33, 6'd41, 6'd28, 6'd45
   };

   localparam rgb6_t palette_g [0:15] = '{
      6'd0,  6'd63, 6'd10, 6'd54, 6'd15, 6'd49, 6'd14, 6'd59,
      6'd22, 6'd14, 6'd29, 6'd19, 6'd33, 6'd62, 6'd31, 6'd45
   };

   localparam rgb6_t palette_b [0:15] = '{
      6'd0,  6'd63, 6'd10, 6'd51, 6'd45, 6'd18, 6'd49, 6'd19,
      6'd7,  6'd2,  6'd27, 6'd19, 6'd33, 6'd39, 6'd57, 6'd45
   };

endpackage

`default_nettype wire

// File: src/vic_top.sv
`timescale 1ns/1ps
`default_nettype none

module vic_top #(
   parameter int h_total  = 48,
   parameter int v_total  = 20,
   parameter int win_x0   = 8,
   parameter int win_x1   = 32,
   parameter int win_y0   = 4,
   parameter int win_y1   = 12,
   parameter int h_vis    = 40,
   parameter int v_vis    = 16,
   parameter int hs_start = 42,
   parameter int hs_len   = 4,
   parameter int vs_start = 17,
   parameter int vs_len   = 2
) (
   input  wire                clk_dot4x,
   input  wire                rst_n,
   input  wire                ce,
   input  wire                rw,
   input  wire vic_pkg::reg_addr_t adi,
   input  wire  [7:0]         dbi,
   output logic [7:0]         dbo,
   output logic               db_oe,
   output logic               irq,
   output vic_pkg::rgb6_t     red,
   output vic_pkg::rgb6_t     green,
   output vic_pkg::rgb6_t     blue,
   output logic               hsync,
   output logic               vsync,
   output logic               active,
   output logic               pix_valid
);

   import vic_pkg::*;

   logic       den;          // register bank levels
   logic [7:0] raster_cmp;
   color_t     border;
   color_t     bg0;
   color_t     bg1;
   logic       pix_en;       // raster timing outputs
   logic [7:0] x;
   logic [7:0] y;
   logic       hs;
   logic       vs;
   logic       vis;
   logic       in_win;
   logic       raster_hit;
   color_t     color_idx;    // pixel stage to palette
   logic       hs_q;
   logic       vs_q;
   logic       vis_q;

   cpu_bus_regs u_regs (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n), .ce(ce), .rw(rw), .adi(adi), .dbi(dbi),
      .raster_y(y), .raster_hit(raster_hit), .dbo(dbo), .db_oe(db_oe), .irq(irq),
      .den(den), .raster_cmp(raster_cmp), .border(border), .bg0(bg0), .bg1(bg1)
   );

   raster_timing #(
      .h_total(h_total), .v_total(v_total), .win_x0(win_x0), .win_x1(win_x1),
      .win_y0(win_y0), .win_y1(win_y1), .h_vis(h_vis), .v_vis(v_vis),
      .hs_start(hs_start), .hs_len(hs_len), .vs_start(vs_start), .vs_len(vs_len)
   ) u_timing (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n), .raster_cmp(raster_cmp), .pix_en(pix_en),
      .x(x), .y(y), .hs(hs), .vs(vs), .vis(vis), .in_win(in_win),
      .raster_hit(raster_hit)
   );

   pixel_color u_color (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n), .pix_en(pix_en), .x(x), .y(y), .hs(hs),
      .vs(vs), .vis(vis), .in_win(in_win), .den(den), .border(border), .bg0(bg0),
      .bg1(bg1), .color_idx(color_idx), .hs_q(hs_q), .vs_q(vs_q), .vis_q(vis_q)
   );

   palette_rgb u_palette (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n), .pix_en(pix_en), .color_idx(color_idx),
      .hs_q(hs_q), .vs_q(vs_q), .vis_q(vis_q), .red(red), .green(green), .blue(blue),
      .hsync(hsync), .vsync(vsync), .active(active), .pix_valid(pix_valid)
   );

endmodule

`default_nettype wire

// File: test/vic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vic_tb;

   import vic_pkg::*;

   localparam int h_total  = 48;   // shrunk raster, same as the DUT defaults
   localparam int v_total  = 20;
   localparam int win_x0   = 8;
   localparam int win_x1   = 32;
   localparam int win_y0   = 4;
   localparam int win_y1   = 12;
   localparam int h_vis    = 40;
   localparam int v_vis    = 16;
   localparam int hs_start = 42;
   localparam int hs_len   = 4;
   localparam int vs_start = 17;
   localparam int vs_len   = 2;

   localparam int op_write    = 0;   // table operations
   localparam int op_read     = 1;   // read and compare with exp
   localparam int op_read_max = 2;   // read, value must not exceed exp
   localparam int op_frames   = 3;   // check frames, then irq against exp[0]
   localparam int op_irq      = 4;   // irq level against exp[0]
   localparam int tbl_size    = 64;

   logic       clk_dot4x;
   logic       rst_n;
   logic       ce;
   logic       rw;
   reg_addr_t  adi;
   logic [7:0] dbi;
   logic [7:0] dbo;
   logic       db_oe;
   logic       irq;
   rgb6_t      red;
   rgb6_t      green;
   rgb6_t      blue;
   logic       hsync;
   logic       vsync;
   logic       active;
   logic       pix_valid;

   int         tbl_op   [tbl_size];
   reg_addr_t  tbl_addr [tbl_size];
   logic [7:0] tbl_data [tbl_size];   // write data, or frame count
   logic [7:0] tbl_exp  [tbl_size];
   int         tbl_n;

   logic [31:0] lfsr_state;
   int          mx;              // model position of the next output pixel
   int          my;
   logic        primed;          // first strobe after reset passed
   logic        arm;             // driver asks for checking to start
   logic        check_on;
   int          pixels_left;
   logic        irq_low_seen;
   logic        sh_den;          // shadow of the register bank
   color_t      sh_border;
   color_t      sh_bg0;
   color_t      sh_bg1;
   logic        sh_irq_en;
   int          cycle_cnt;
   int          cycle_limit;

   vic_top #(
      .h_total(h_total), .v_total(v_total), .win_x0(win_x0), .win_x1(win_x1),
      .win_y0(win_y0), .win_y1(win_y1), .h_vis(h_vis), .v_vis(v_vis),
      .hs_start(hs_start), .hs_len(hs_len), .vs_start(vs_start), .vs_len(vs_len)
   ) UUT (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n), .ce(ce), .rw(rw), .adi(adi), .dbi(dbi),
      .dbo(dbo), .db_oe(db_oe), .irq(irq), .red(red), .green(green), .blue(blue),
      .hsync(hsync), .vsync(vsync), .active(active), .pix_valid(pix_valid)
   );

   always #4 clk_dot4x = ~clk_dot4x;   // 8 ns period

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_rgb(input string name, input rgb6_t got, input rgb6_t exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic color_t random_color();
      color_t c;
      c = '0;
      for (int i = 0; i < 4; i++) begin
         lfsr_state = lfsr_step(lfsr_state);   // one step per bit
         c = {c[2:0], lfsr_state[0]};
      end
      return c;
   endfunction

   task automatic add_entry(input int op, input reg_addr_t addr, input logic [7:0] data,
                            input logic [7:0] exp);
      tbl_op[tbl_n]   = op;
      tbl_addr[tbl_n] = addr;
      tbl_data[tbl_n] = data;
      tbl_exp[tbl_n]  = exp;
      tbl_n = tbl_n + 1;
   endtask

   task automatic build_table();
      color_t c;
      color_t frame_col;   // border around the checker window
      color_t tile_col;    // bg0 tiles of the checker
      add_entry(op_write, reg_border, 8'h0e, 8'h00);
      add_entry(op_read, reg_border, 8'h00, 8'hfe);     // upper nibble reads 1111
      c = random_color();
      add_entry(op_write, reg_bg0, {4'h0, c}, 8'h00);
      add_entry(op_read, reg_bg0, 8'h00, {4'hf, c});
      c = random_color();
      add_entry(op_write, reg_bg1, {4'h0, c}, 8'h00);
      add_entry(op_read, reg_bg1, 8'h00, {4'hf, c});
      add_entry(op_write, reg_ctrl, 8'h00, 8'h00);
      add_entry(op_read, reg_ctrl, 8'h00, 8'hef);       // den clear
      add_entry(op_write, reg_irq_en, 8'h00, 8'h00);
      add_entry(op_read, reg_irq_en, 8'h00, 8'hfe);
      add_entry(op_read, 6'h3f, 8'h00, 8'hff);          // unmapped
      add_entry(op_read, 6'h00, 8'h00, 8'hff);
      add_entry(op_read, 6'h13, 8'h00, 8'hff);
      add_entry(op_frames, 6'h00, 8'd1, 8'h01);         // border only frame
      frame_col = random_color();
      add_entry(op_write, reg_border, {4'h0, frame_col}, 8'h00);
      add_entry(op_write, reg_ctrl, 8'h10, 8'h00);      // display on
      add_entry(op_read, reg_ctrl, 8'h00, 8'hff);
      tile_col = random_color();
      while (tile_col == frame_col)
         tile_col = random_color();                     // tiles stand out from the frame
      add_entry(op_write, reg_bg0, {4'h0, tile_col}, 8'h00);
      add_entry(op_read, reg_bg0, 8'h00, {4'hf, tile_col});
      c = random_color();
      while ((c == frame_col) || (c == tile_col))
         c = random_color();
      add_entry(op_write, reg_bg1, {4'h0, c}, 8'h00);
      add_entry(op_read, reg_bg1, 8'h00, {4'hf, c});
      add_entry(op_frames, 6'h00, 8'd2, 8'h01);         // checker window
      add_entry(op_write, reg_raster, 8'hfe, 8'h00);    // line never reached
      add_entry(op_write, reg_irq_stat, 8'h01, 8'h00);
      add_entry(op_write, reg_irq_en, 8'h01, 8'h00);
      add_entry(op_irq, 6'h00, 8'h00, 8'h01);
      add_entry(op_read, reg_irq_en, 8'h00, 8'hff);
      add_entry(op_read, reg_irq_stat, 8'h00, 8'h7e);
      add_entry(op_write, reg_raster, 8'd10, 8'h00);
      add_entry(op_frames, 6'h00, 8'd1, 8'h00);         // irq low by frame end
      add_entry(op_read_max, reg_raster, 8'h00, 8'(v_total));
      add_entry(op_read, reg_irq_stat, 8'h00, 8'hff);
      add_entry(op_write, reg_raster, 8'hfe, 8'h00);
      add_entry(op_write, reg_irq_stat, 8'h01, 8'h00);  // write 1 clears
      add_entry(op_irq, 6'h00, 8'h00, 8'h01);
      add_entry(op_read, reg_irq_stat, 8'h00, 8'h7e);
      add_entry(op_write, reg_irq_en, 8'h00, 8'h00);
      add_entry(op_write, reg_raster, 8'd5, 8'h00);
      add_entry(op_frames, 6'h00, 8'd1, 8'h01);         // disabled, irq stays high
      add_entry(op_read, reg_irq_stat, 8'h00, 8'h7f);   // event latched, not pending
   endtask

   // one ce low cycle, called and left at 1 ns after a rising edge
   task automatic bus_write(input reg_addr_t addr, input logic [7:0] data);
      ce  = 1'b0;
      rw  = 1'b0;
      adi = addr;
      dbi = data;
      @(posedge clk_dot4x);
      #1;
      ce = 1'b1;
      rw = 1'b1;
      case (addr)
         reg_ctrl:   sh_den    = data[4];
         reg_irq_en: sh_irq_en = data[0];
         reg_border: sh_border = data[3:0];
         reg_bg0:    sh_bg0    = data[3:0];
         reg_bg1:    sh_bg1    = data[3:0];
         default: ;
      endcase
   endtask

   task automatic bus_read(input reg_addr_t addr, output logic [7:0] val);
      ce  = 1'b0;
      rw  = 1'b1;
      adi = addr;
      @(posedge clk_dot4x);
      #1;
      ce = 1'b1;
      check_bit("db_oe", db_oe, 1'b1);   // data window opens
      val = dbo;
      @(posedge clk_dot4x);
      #1;
      check_bit("db_oe", db_oe, 1'b0);   // and lasts one cycle
   endtask

   task automatic run_frames(input int n);
      repeat (12) @(posedge clk_dot4x);   // drain pixels latched before the writes
      #1;
      pixels_left  = n * h_total * v_total;
      irq_low_seen = 1'b0;
      arm          = 1'b1;
      while (arm || check_on)
         @(posedge clk_dot4x);
      #1;
   endtask

   task automatic apply_entry(input int i);
      logic [7:0] rd_val;
      case (tbl_op[i])
         op_write: bus_write(tbl_addr[i], tbl_data[i]);
         op_read: begin
            bus_read(tbl_addr[i], rd_val);
            check_byte($sformatf("dbo for address 0x%h", tbl_addr[i]), rd_val, tbl_exp[i]);
         end
         op_read_max: begin
            bus_read(tbl_addr[i], rd_val);
            if (rd_val > tbl_exp[i])
               abort_run($sformatf("raster register read line %0d, more than %0d lines",
                                   rd_val, tbl_exp[i]));
         end
         op_frames: begin
            run_frames(int'(tbl_data[i]));
            check_bit("irq", irq, tbl_exp[i][0]);
         end
         op_irq: check_bit("irq", irq, tbl_exp[i][0]);
         default: abort_run($sformatf("table entry %0d holds an unknown operation", i));
      endcase
   endtask

   // raster model, sampled mid-cycle where the outputs are stable
   always @(negedge clk_dot4x) begin
      color_t col;
      rgb6_t  er;
      rgb6_t  eg;
      rgb6_t  eb;
      logic   ev;
      logic   ewin;
      if (rst_n === 1'b1) begin
         if (check_on) begin
            if (!sh_irq_en)
               check_bit("irq", irq, 1'b1);   // disabled source never pulls irq
            else if (irq === 1'b0)
               irq_low_seen = 1'b1;
            else if (irq_low_seen)
               abort_run("irq went high again while no status clear was written");
         end
         if (pix_valid === 1'b1) begin
            if (!primed) begin
               primed = 1'b1;   // first strobe carries the reset pipeline, no pixel
            end else begin
               if (arm) begin
                  check_on = 1'b1;
                  arm      = 1'b0;
               end
               if (check_on) begin
                  ev   = (mx < h_vis) && (my < v_vis);
                  ewin = (mx >= win_x0) && (mx < win_x1) && (my >= win_y0) && (my < win_y1);
                  if (!ev)
                     col = '0;
                  else if (ewin && sh_den)
                     col = (mx[2] ^ my[2]) ? sh_bg1 : sh_bg0;
                  else
                     col = sh_border;
                  er = ev ? palette_r[col] : 6'd0;
                  eg = ev ? palette_g[col] : 6'd0;
                  eb = ev ? palette_b[col] : 6'd0;
                  check_rgb($sformatf("red at x=%0d y=%0d", mx, my), red, er);
                  check_rgb($sformatf("green at x=%0d y=%0d", mx, my), green, eg);
                  check_rgb($sformatf("blue at x=%0d y=%0d", mx, my), blue, eb);
                  check_bit($sformatf("active at x=%0d y=%0d", mx, my), active, ev);
                  check_bit($sformatf("hsync at x=%0d y=%0d", mx, my), hsync,
                            (mx >= hs_start) && (mx < hs_start + hs_len));
                  check_bit($sformatf("vsync at x=%0d y=%0d", mx, my), vsync,
                            (my >= vs_start) && (my < vs_start + vs_len));
                  pixels_left = pixels_left - 1;
                  if (pixels_left == 0)
                     check_on = 1'b0;
               end
               mx = mx + 1;   // x runs fastest
               if (mx == h_total) begin
                  mx = 0;
                  my = (my == v_total - 1) ? 0 : my + 1;
               end
            end
         end
      end
   end

   always @(posedge clk_dot4x) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
         abort_run($sformatf("run did not finish within %0d clock cycles", cycle_limit));
   end

   initial begin
      int frames;
      clk_dot4x    = 1'b0;
      rst_n        = 1'b0;
      ce           = 1'b1;   // bus idle
      rw           = 1'b1;
      adi          = '0;
      dbi          = '0;
      lfsr_state   = 32'd67800;
      mx           = 0;
      my           = 0;
      primed       = 1'b0;
      arm          = 1'b0;
      check_on     = 1'b0;
      pixels_left  = 0;
      irq_low_seen = 1'b0;
      sh_den       = 1'b0;   // register reset values
      sh_border    = '0;
      sh_bg0       = '0;
      sh_bg1       = '0;
      sh_irq_en    = 1'b0;
      cycle_cnt    = 0;
      tbl_n        = 0;
      build_table();
      frames = 0;
      for (int i = 0; i < tbl_n; i++)
         if (tbl_op[i] == op_frames)
            frames = frames + int'(tbl_data[i]);
      cycle_limit = (frames + 2) * h_total * v_total * 4 + 200;

      repeat (8) @(posedge clk_dot4x);
      #1;
      rst_n = 1'b1;
      check_bit("irq", irq, 1'b1);
      check_bit("db_oe", db_oe, 1'b0);
      check_bit("pix_valid", pix_valid, 1'b0);
      check_bit("hsync", hsync, 1'b0);
      check_bit("vsync", vsync, 1'b0);
      check_bit("active", active, 1'b0);

      for (int i = 0; i < tbl_n; i++)
         apply_entry(i);

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: vic_sim.f
src/vic_pkg.sv
src/cpu_bus_regs.sv
src/raster_timing.sv
src/pixel_color.sv
src/palette_rgb.sv
src/vic_top.sv
test/vic_tb.sv
